// ==== common/pg_defines.svh ====
`ifndef PG_DEFINES_SVH
`define PG_DEFINES_SVH

// ------------------------------------------------------------
// Cluster geometry
// ------------------------------------------------------------

// Physical clusters on the part, the datapath also builds for 2 or 8
`define PG_NUM_CLUSTERS 4

// Bits in one per-cluster field
`define PG_FIELD_W 8

// Index width needed to name one physical cluster
`define PG_SEL_W ($clog2(`PG_NUM_CLUSTERS))

// Words buffered between the remap and the dispatcher
`define PG_FIFO_DEPTH 4

// Remap direction codes for the DIR parameter of pg_remap
`define PG_L2P 0
`define PG_P2L 1

`endif

// ==== common/pg_pkg.sv ====
`include "pg_defines.svh"

package pg_pkg;

	// ------------------------------------------------------------
	// Per-cluster vectors
	// ------------------------------------------------------------

	// One bit per physical cluster
	// Used for the cluster-present vector and for the busy flags
	typedef logic [`PG_NUM_CLUSTERS-1:0] cluster_mask_t;

	// Index of a single cluster
	typedef logic [`PG_SEL_W-1:0] cluster_id_t;

	// Payload carried for one cluster
	typedef logic [`PG_FIELD_W-1:0] field_t;

	// ------------------------------------------------------------
	// Cluster word
	// ------------------------------------------------------------

	// One field per cluster slot
	// On the logical side slot k belongs to logical cluster k
	// On the physical side slot k belongs to physical cluster k
	typedef struct packed {
		field_t [`PG_NUM_CLUSTERS-1:0] slot;
	} cluster_word_t;

	// ------------------------------------------------------------
	// Dispatcher FSM
	// ------------------------------------------------------------

	// IDLE waits for a buffered word
	// SEND walks the enabled clusters of the head word
	typedef enum logic {
		DISP_IDLE = 1'b0,
		DISP_SEND = 1'b1
	} dispatch_state_t;

endpackage

// ==== rtl/pg_cluster_top.sv ====
`include "pg_defines.svh"

module pg_cluster_top (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  pg_pkg::cluster_mask_t i_cpv,

	// Logical word write side
	input  logic                  i_wr,
	input  pg_pkg::cluster_word_t i_log_word,
	output logic                  o_full,

	// Physical dispatch side
	output logic                  o_clu_valid,
	output pg_pkg::cluster_id_t   o_clu_id,
	output pg_pkg::field_t        o_clu_data,

	// Busy flags, physical in and logical out
	input  pg_pkg::cluster_mask_t i_phys_busy,
	output pg_pkg::cluster_mask_t o_log_busy
);

	// Remapped word on its way into the FIFO
	pg_pkg::cluster_word_t phys_word;
	// Head of the FIFO as seen by the dispatcher
	pg_pkg::cluster_word_t head_word;
	logic                  fifo_empty;
	logic                  disp_pop;
	// Busy flags spread over one field per cluster, the flag sits in bit 0
	pg_pkg::cluster_word_t busy_phys_word;
	pg_pkg::cluster_word_t busy_log_word;

	// ------------------------------------------------------------
	// Write path
	// ------------------------------------------------------------

	// Logical fields are steered to the physical clusters that back them
	// Fused-off physical slots carry zeros
	pg_remap #(
		.DIR  (`PG_L2P),
		.FILL (0)
	) u_log2phys (
		.i_cpv  (i_cpv),
		.i_word (i_log_word),
		.o_word (phys_word)
	);

	pg_word_fifo u_fifo (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_wr    (i_wr),
		.i_wdata (phys_word),
		.i_pop   (disp_pop),
		.o_rdata (head_word),
		.o_full  (o_full),
		.o_empty (fifo_empty)
	);

	pg_phys_dispatch u_dispatch (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_cpv       (i_cpv),
		.i_empty     (fifo_empty),
		.i_word      (head_word),
		.o_pop       (disp_pop),
		.o_clu_valid (o_clu_valid),
		.o_clu_id    (o_clu_id),
		.o_clu_data  (o_clu_data)
	);

	// ------------------------------------------------------------
	// Busy path
	// ------------------------------------------------------------

	// Each busy bit travels as bit 0 of its own cluster field
	// The all-ones fill makes bit 0 of a missing logical cluster read as busy
	for (genvar g = 0; g < `PG_NUM_CLUSTERS; g++) begin : g_busy
		assign busy_phys_word.slot[g] = pg_pkg::field_t'(i_phys_busy[g]);
		assign o_log_busy[g]          = busy_log_word.slot[g][0];
	end

	// Logical clusters beyond the popcount read as busy
	pg_remap #(
		.DIR  (`PG_P2L),
		.FILL (1)
	) u_busy_p2l (
		.i_cpv  (i_cpv),
		.i_word (busy_phys_word),
		.o_word (busy_log_word)
	);

endmodule

// ==== rtl/pg_phys_dispatch.sv ====
`include "pg_defines.svh"

module pg_phys_dispatch (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  pg_pkg::cluster_mask_t i_cpv,
	input  logic                  i_empty,
	input  pg_pkg::cluster_word_t i_word,
	output logic                  o_pop,
	output logic                  o_clu_valid,
	output pg_pkg::cluster_id_t   o_clu_id,
	output pg_pkg::field_t        o_clu_data
);

	pg_pkg::dispatch_state_t state;
	// Physical cluster currently being sent
	pg_pkg::cluster_id_t     idx;

	// Lowest enabled cluster, and the next enabled one above idx
	pg_pkg::cluster_id_t     first_id;
	pg_pkg::cluster_id_t     next_id;
	logic                    has_next;

	// ------------------------------------------------------------
	// Enabled-cluster search
	// ------------------------------------------------------------

	// Scan from the top down so the last hit is the lowest index
	always_comb begin
		first_id = '0;
		next_id  = '0;
		has_next = 1'b0;
		for (int i = `PG_NUM_CLUSTERS - 1; i >= 0; i--) begin
			if (i_cpv[i]) begin
				first_id = pg_pkg::cluster_id_t'(i);
				if (i > int'(idx)) begin
					next_id  = pg_pkg::cluster_id_t'(i);
					has_next = 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------

	// IDLE sees a buffered word and loads the first enabled cluster
	// SEND emits one cluster per cycle and falls back to IDLE after the last
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= pg_pkg::DISP_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				pg_pkg::DISP_IDLE: begin
					if (!i_empty) begin
						state <= pg_pkg::DISP_SEND;
						idx   <= first_id;
					end
				end
				pg_pkg::DISP_SEND: begin
					if (has_next) begin
						idx <= next_id;
					end else begin
						state <= pg_pkg::DISP_IDLE;
					end
				end
				default: state <= pg_pkg::DISP_IDLE;
			endcase
		end
	end

	// Outputs come straight from the state, one pulse per SEND cycle
	assign o_clu_valid = (state == pg_pkg::DISP_SEND);
	assign o_clu_id    = idx;
	assign o_clu_data  = i_word.slot[idx];
	// The head word is released together with its last pulse
	assign o_pop       = (state == pg_pkg::DISP_SEND) && !has_next;

	// ------------------------------------------------------------
	// Assertions
	// ------------------------------------------------------------

	// A part always keeps at least one working cluster
	a_cpv_nonzero: assert property (@(posedge i_clk) disable iff (i_rst) i_cpv != '0)
		else $error("pg_phys_dispatch: cluster-present vector is zero");

	// The present vector may only move while the dispatcher is idle
	a_cpv_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		(state == pg_pkg::DISP_SEND) |-> $stable(i_cpv))
		else $error("pg_phys_dispatch: cluster-present vector changed during a word");

endmodule

// ==== rtl/pg_remap.sv ====
`include "pg_defines.svh"

module pg_remap #(
	// Direction of the remap, logical to physical or the reverse
	parameter int DIR  = `PG_L2P,
	// Value for slots with no source, 0 gives zeros and 1 gives ones
	parameter int FILL = 0
) (
	input  pg_pkg::cluster_mask_t i_cpv,
	input  pg_pkg::cluster_word_t i_word,
	output pg_pkg::cluster_word_t o_word
);

	// Fill pattern for slots that receive no field
	localparam pg_pkg::field_t FILL_VAL = {`PG_FIELD_W{FILL == 1}};

	// Per output slot, which input slot feeds it
	pg_pkg::cluster_id_t [`PG_NUM_CLUSTERS-1:0] sel;
	// Per output slot, whether it has a source at all
	pg_pkg::cluster_mask_t                      slot_ok;

	// ------------------------------------------------------------
	// Elaboration checks
	// ------------------------------------------------------------

	if ((DIR != `PG_L2P) && (DIR != `PG_P2L)) begin : g_bad_dir
		$error("pg_remap: DIR must be L2P or P2L");
	end

	if ((FILL != 0) && (FILL != 1)) begin : g_bad_fill
		$error("pg_remap: FILL must be 0 or 1");
	end

	// ------------------------------------------------------------
	// Select generation
	// ------------------------------------------------------------

	// Walk the present vector from cluster 0 upward and count the enabled ones
	// The running count is the logical number of the current physical cluster
	always_comb begin
		logic [`PG_SEL_W:0] cnt;

		cnt     = '0;
		sel     = '0;
		slot_ok = '0;
		for (int i = 0; i < `PG_NUM_CLUSTERS; i++) begin
			if (i_cpv[i]) begin
				if (DIR == `PG_L2P) begin
					// Physical slot i takes logical slot cnt
					sel[i]     = cnt[`PG_SEL_W-1:0];
					slot_ok[i] = 1'b1;
				end else begin
					// Logical slot cnt takes physical slot i
					sel[cnt[`PG_SEL_W-1:0]]     = pg_pkg::cluster_id_t'(i);
					slot_ok[cnt[`PG_SEL_W-1:0]] = 1'b1;
				end
				cnt = cnt + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// Field steering
	// ------------------------------------------------------------

	// One mux per output slot, slots without a source read the fill value
	// For L2P these are the fused-off physical clusters
	// For P2L these are the logical slots at or above the popcount
	for (genvar g = 0; g < `PG_NUM_CLUSTERS; g++) begin : g_slot
		assign o_word.slot[g] = slot_ok[g] ? i_word.slot[sel[g]] : FILL_VAL;
	end

endmodule

// ==== rtl/pg_word_fifo.sv ====
`include "pg_defines.svh"

module pg_word_fifo (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_wr,
	input  pg_pkg::cluster_word_t i_wdata,
	input  logic                  i_pop,
	output pg_pkg::cluster_word_t o_rdata,
	output logic                  o_full,
	output logic                  o_empty
);

	localparam int DEPTH = `PG_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Word storage, the payload needs no reset
	pg_pkg::cluster_word_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// ------------------------------------------------------------
	// Storage and pointers
	// ------------------------------------------------------------

	always_ff @(posedge i_clk) begin
		if (i_wr) begin
			mem[wr_ptr] <= i_wdata;
		end
	end

	// Pointers wrap explicitly so that a depth other than a power of two works
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (i_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// A write and a pop in the same cycle leave the count as it is
			case ({i_wr, i_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head word is visible without a read cycle
	assign o_rdata = mem[rd_ptr];
	assign o_full  = (count == CNT_W'(DEPTH));
	assign o_empty = (count == '0);

	// ------------------------------------------------------------
	// Assertions
	// ------------------------------------------------------------

	// The producer has only the full level as back-pressure
	a_no_wr_full: assert property (@(posedge i_clk) disable iff (i_rst) i_wr |-> !o_full)
		else $error("pg_word_fifo: write while full");

	// The dispatcher pops only after it has seen a non-empty FIFO
	a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst) i_pop |-> !o_empty)
		else $error("pg_word_fifo: pop while empty");

endmodule

// ==== src.f ====
+incdir+common
common/pg_pkg.sv
rtl/pg_remap.sv
rtl/pg_word_fifo.sv
rtl/pg_phys_dispatch.sv
rtl/pg_cluster_top.sv
verification/pg_checker.sv
verification/tb_pg_cluster.sv

// ==== verification/pg_checker.sv ====
`include "pg_defines.svh"

module pg_checker (
	input  logic                                       i_clk,
	input  logic                                       i_rst,
	input  logic                                       i_clu_valid,
	input  pg_pkg::cluster_id_t                        i_clu_id,
	input  pg_pkg::field_t                             i_clu_data,
	input  logic                                       i_full,
	input  pg_pkg::cluster_mask_t                      i_log_busy,
	// Expected pulse list of one written word, high for a single cycle
	input  logic                                       i_exp_push,
	input  int                                         i_exp_cnt,
	input  pg_pkg::cluster_id_t [`PG_NUM_CLUSTERS-1:0] i_exp_ids,
	input  pg_pkg::field_t [`PG_NUM_CLUSTERS-1:0]      i_exp_data,
	// Expected logical busy flags, compared while i_busy_chk is high
	input  logic                                       i_busy_chk,
	input  pg_pkg::cluster_mask_t                      i_exp_busy,
	output int                                         o_pending,
	output int                                         o_errors
);

	localparam int EW = `PG_SEL_W + `PG_FIELD_W;

	// Each entry holds the last-pulse flag, the physical id and the field
	logic [EW:0] exp_q [$];
	logic [EW:0] head;
	// Words that the FIFO should hold right now
	int          occ;
	// Cycles since a write into an idle DUT
	int          lat_age;
	logic        lat_armed;

	task automatic flag_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		o_errors = o_errors + 1;
	endtask

	// ------------------------------------------------------------
	// Comparison at the falling edge where all outputs are settled
	// ------------------------------------------------------------

	always @(negedge i_clk) begin
		if (i_rst) begin
			exp_q.delete();
			occ       = 0;
			lat_age   = 0;
			lat_armed = 1'b0;
			o_errors  = 0;
		end else begin
			// The full level shows the FIFO count left by the last rising edge
			if (i_full !== (occ == `PG_FIFO_DEPTH)) begin
				flag_error($sformatf("o_full is %b with %0d words buffered", i_full, occ));
			end
			// A word written into an idle DUT must pulse exactly two cycles after its write
			if (lat_armed) begin
				lat_age = lat_age + 1;
				if (i_clu_valid || lat_age >= 2) begin
					if (!i_clu_valid || lat_age != 2) begin
						flag_error($sformatf("first pulse at cycle %0d after the write, valid %b",
							lat_age, i_clu_valid));
					end
					lat_armed = 1'b0;
				end
			end
			if (i_clu_valid) begin
				if (exp_q.size() == 0) begin
					flag_error($sformatf("unexpected pulse id %0d data %h", i_clu_id, i_clu_data));
				end else begin
					head = exp_q.pop_front();
					if ({i_clu_id, i_clu_data} !== head[EW-1:0]) begin
						flag_error($sformatf("pulse id %0d data %h, expected id %0d data %h",
							i_clu_id, i_clu_data, head[`PG_FIELD_W +: `PG_SEL_W],
							head[`PG_FIELD_W-1:0]));
					end
					// The FIFO releases the word together with its last pulse
					if (head[EW]) begin
						occ = occ - 1;
					end
				end
			end
			if (i_exp_push) begin
				if (exp_q.size() == 0) begin
					lat_armed = 1'b1;
					lat_age   = 0;
				end
				for (int k = 0; k < i_exp_cnt; k++) begin
					exp_q.push_back({(k == i_exp_cnt - 1), i_exp_ids[k], i_exp_data[k]});
				end
				occ = occ + 1;
			end
			// Busy flags are combinational so they match within the same cycle
			if (i_busy_chk && (i_log_busy !== i_exp_busy)) begin
				flag_error($sformatf("o_log_busy %b, expected %b", i_log_busy, i_exp_busy));
			end
		end
		o_pending = exp_q.size();
	end

endmodule

// ==== verification/tb_pg_cluster.sv ====
`include "pg_defines.svh"

module tb_pg_cluster;

	localparam int N     = `PG_NUM_CLUSTERS;
	// Longest any single wait may last, in clock cycles
	localparam int LIMIT = 400;

	// DUT ports, named as on pg_cluster_top
	logic                  i_clk;
	logic                  i_rst;
	pg_pkg::cluster_mask_t i_cpv;
	logic                  i_wr;
	pg_pkg::cluster_word_t i_log_word;
	logic                  o_full;
	logic                  o_clu_valid;
	pg_pkg::cluster_id_t   o_clu_id;
	pg_pkg::field_t        o_clu_data;
	pg_pkg::cluster_mask_t i_phys_busy;
	pg_pkg::cluster_mask_t o_log_busy;

	// Expected values handed to the checker
	logic                        exp_push;
	int                          exp_cnt;
	pg_pkg::cluster_id_t [N-1:0] exp_ids;
	pg_pkg::field_t [N-1:0]      exp_data;
	logic                        busy_chk;
	pg_pkg::cluster_mask_t       exp_busy;
	int                          pending;
	int                          errors;

	int tests;
	int failed;
	int err_mark;

	pg_cluster_top u_dut (.*);

	pg_checker u_chk (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_clu_valid (o_clu_valid),
		.i_clu_id    (o_clu_id),
		.i_clu_data  (o_clu_data),
		.i_full      (o_full),
		.i_log_busy  (o_log_busy),
		.i_exp_push  (exp_push),
		.i_exp_cnt   (exp_cnt),
		.i_exp_ids   (exp_ids),
		.i_exp_data  (exp_data),
		.i_busy_chk  (busy_chk),
		.i_exp_busy  (exp_busy),
		.o_pending   (pending),
		.o_errors    (errors)
	);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------

	// Pulses come in ascending physical order and the k-th enabled cluster carries slot k
	function automatic void expected_pulses(input pg_pkg::cluster_word_t lw,
		input pg_pkg::cluster_mask_t cpv, output int cnt,
		output pg_pkg::cluster_id_t [N-1:0] ids, output pg_pkg::field_t [N-1:0] data);
		cnt  = 0;
		ids  = '0;
		data = '0;
		for (int p = 0; p < N; p++) begin
			if (cpv[p]) begin
				ids[cnt]  = pg_pkg::cluster_id_t'(p);
				data[cnt] = lw.slot[cnt];
				cnt++;
			end
		end
	endfunction

	// Logical slot k takes the busy flag of the k-th enabled cluster and the rest read busy
	function automatic pg_pkg::cluster_mask_t expected_busy(input pg_pkg::cluster_mask_t pb,
		input pg_pkg::cluster_mask_t cpv);
		int k;
		expected_busy = '1;
		k = 0;
		for (int p = 0; p < N; p++) begin
			if (cpv[p]) begin
				expected_busy[k] = pb[p];
				k++;
			end
		end
	endfunction

	function automatic pg_pkg::cluster_mask_t random_cpv();
		return pg_pkg::cluster_mask_t'($urandom % ((1 << N) - 1)) + 1'b1;
	endfunction

	// ------------------------------------------------------------
	// Stimulus tasks
	// ------------------------------------------------------------

	task automatic report_hang(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Errors found");
		$finish;
	endtask

	// Writes one random word once the FIFO has room and returns at the write edge
	task automatic write_random_word();
		int                          waited;
		int                          cnt;
		pg_pkg::cluster_word_t       lw;
		pg_pkg::cluster_id_t [N-1:0] ids;
		pg_pkg::field_t [N-1:0]      data;
		waited = 0;
		for (int k = 0; k < N; k++) begin
			lw.slot[k] = pg_pkg::field_t'($urandom);
		end
		@(posedge i_clk);
		while (o_full && waited < LIMIT) begin
			@(posedge i_clk);
			waited++;
		end
		if (o_full) begin
			report_hang("the FIFO to leave the full level");
		end else begin
			expected_pulses(lw, i_cpv, cnt, ids, data);
			i_wr       <= 1'b1;
			i_log_word <= lw;
			exp_push   <= 1'b1;
			exp_cnt    <= cnt;
			exp_ids    <= ids;
			exp_data   <= data;
			@(posedge i_clk);
			i_wr       <= 1'b0;
			exp_push   <= 1'b0;
		end
	endtask

	// The queue is empty once the last pulse of the last word has been seen
	task automatic wait_drained();
		int waited;
		waited = 0;
		while (pending != 0 && waited < LIMIT) begin
			@(posedge i_clk);
			waited++;
		end
		if (pending != 0) begin
			report_hang("the last pulse of the queued words");
		end
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = errors - err_mark;
		$display("Test %s finished with %0d errors", name, errs);
		tests++;
		if (errs != 0) begin
			failed++;
		end
		err_mark = errors;
	endtask

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------

	initial begin
		pg_pkg::cluster_mask_t pb;
		pg_pkg::cluster_mask_t c;

		void'($urandom(32'hb8c00611));
		i_rst       = 1'b1;
		i_cpv       = '1;
		i_wr        = 1'b0;
		i_log_word  = '0;
		i_phys_busy = '0;
		exp_push    = 1'b0;
		exp_cnt     = 0;
		exp_ids     = '0;
		exp_data    = '0;
		busy_chk    = 1'b0;
		exp_busy    = '0;
		tests       = 0;
		failed      = 0;
		err_mark    = 0;
		repeat (8) @(posedge i_clk);
		i_rst <= 1'b0;

		// An idle DUT shows no pulse and no full level
		repeat (10) @(posedge i_clk);
		finish_test("reset_idle");

		// With every cluster present the word passes through in slot order
		repeat (4) write_random_word();
		wait_drained();
		finish_test("all_present");

		// The checker times the first pulse of a lone write
		write_random_word();
		wait_drained();
		finish_test("first_pulse_latency");

		// The present vector only moves while the FIFO is empty and the dispatcher idles
		repeat (12) begin
			i_cpv <= random_cpv();
			repeat (3) write_random_word();
			wait_drained();
		end
		finish_test("random_present");

		// Five cycles per word drain slower than a write every other cycle
		i_cpv <= '1;
		repeat (12) write_random_word();
		wait_drained();
		finish_test("full_burst");

		repeat (24) begin
			@(posedge i_clk);
			c  = random_cpv();
			pb = pg_pkg::cluster_mask_t'($urandom);
			i_cpv       <= c;
			i_phys_busy <= pb;
			exp_busy    <= expected_busy(pb, c);
			busy_chk    <= 1'b1;
		end
		@(posedge i_clk);
		busy_chk <= 1'b0;
		finish_test("busy_remap");

		$display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
